/* flist.f */
source/tunnel_pkg.sv
source/tagged_demux_fifo.sv
source/channel_tunnel_in.sv
source/channel_tunnel_out.sv
source/link_stage.sv
source/channel_tunnel.sv
source/tunnel_pair.sv
tests/tb_tunnel_pair.sv

/* run_sim.sh */
#!/bin/sh
# builds the tunnel testbench with Verilator and runs it
# exit status is the simulator's own, nonzero when the run fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_tunnel_pair \
   -f flist.f \
   --Mdir obj_dir \
   -o sim_tunnel_pair
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build stopped with status $status"
   exit $status
fi

./obj_dir/sim_tunnel_pair
status=$?
if [ $status -ne 0 ]; then
   echo "simulation stopped with status $status"
fi
exit $status

/* source/channel_tunnel.sv */
// one end of the tunnel, sender and receiver joined
// the receiver feeds returned credits and owed counts to the sender
// the sender clears the owed counts when its credit flit leaves

`timescale 1ns/10ps

module channel_tunnel
   import tunnel_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      arst_n_i,

   // local channels into the tunnel
   input  ch_word_t [num_ch_lp-1:0]  ch_data_i,
   input  logic     [num_ch_lp-1:0]  ch_valid_i,
   output logic     [num_ch_lp-1:0]  ch_ready_o,

   // local channels out of the tunnel
   output ch_word_t [num_ch_lp-1:0]  ch_data_o,
   output logic     [num_ch_lp-1:0]  ch_valid_o,
   input  logic     [num_ch_lp-1:0]  ch_ready_i,

   // outgoing link
   output tunnel_flit_t              link_o,
   output logic                      link_valid_o,
   input  logic                      link_ready_i,

   // incoming link
   input  tunnel_flit_t              link_i,
   input  logic                      link_valid_i,
   output logic                      link_ready_o
);

   credit_vec_t local_credit;
   logic        local_credit_valid;
   credit_vec_t pending_credit;
   logic        pending_clear;

   channel_tunnel_out u_out (
      .clk_i                (clk_i),
      .arst_n_i             (arst_n_i),
      .ch_data_i            (ch_data_i),
      .ch_valid_i           (ch_valid_i),
      .ch_ready_o           (ch_ready_o),
      .local_credit_i       (local_credit),
      .local_credit_valid_i (local_credit_valid),
      .pending_credit_i     (pending_credit),
      .pending_clear_o      (pending_clear),
      .link_o               (link_o),
      .link_valid_o         (link_valid_o),
      .link_ready_i         (link_ready_i)
   );

   channel_tunnel_in u_in (
      .clk_i                (clk_i),
      .arst_n_i             (arst_n_i),
      .link_i               (link_i),
      .link_valid_i         (link_valid_i),
      .link_ready_o         (link_ready_o),
      .ch_data_o            (ch_data_o),
      .ch_valid_o           (ch_valid_o),
      .ch_ready_i           (ch_ready_i),
      .local_credit_o       (local_credit),
      .local_credit_valid_o (local_credit_valid),
      .pending_credit_o     (pending_credit),
      .pending_clear_i      (pending_clear)
   );

endmodule

/* source/channel_tunnel_in.sv */
// receiving half of one tunnel end
// demuxes link flits into the channel fifos and tracks words consumed per channel
// consumed counts go to the local sender, which returns them as a credit flit
// credits from the far end are handed to the local sender as a pulse

`timescale 1ns/10ps

module channel_tunnel_in
   import tunnel_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         arst_n_i,

   // from the link
   input  tunnel_flit_t                 link_i,
   input  logic                         link_valid_i,
   output logic                         link_ready_o,

   // channel outputs
   output ch_word_t    [num_ch_lp-1:0]  ch_data_o,
   output logic        [num_ch_lp-1:0]  ch_valid_o,
   input  logic        [num_ch_lp-1:0]  ch_ready_i,

   // credits returned by the far end, always accepted
   output credit_vec_t                  local_credit_o,
   output logic                         local_credit_valid_o,

   // counts still owed to the far end, cleared once the credit flit leaves
   output credit_vec_t                  pending_credit_o,
   input  logic                         pending_clear_i
);

   logic        [num_ch_lp-1:0] taken;
   credit_vec_t                 pending_q;

   tagged_demux_fifo u_demux (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .flit_i         (link_i),
      .flit_valid_i   (link_valid_i),
      .flit_ready_o   (link_ready_o),
      .ch_data_o      (ch_data_o),
      .ch_valid_o     (ch_valid_o),
      .ch_ready_i     (ch_ready_i),
      .credit_o       (local_credit_o),
      .credit_valid_o (local_credit_valid_o)
   );

   assign taken = ch_valid_o & ch_ready_i;

   // a word taken in the clearing cycle is not part of the flit, keep it
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         pending_q <= '0;
      else
      begin
         for (int i = 0; i < num_ch_lp; i++)
         begin
            if (pending_clear_i)
               pending_q[i] <= credit_width_lp'(taken[i]);
            else
               pending_q[i] <= pending_q[i] + credit_width_lp'(taken[i]);
         end
      end
   end

   assign pending_credit_o = pending_q;

endmodule

/* source/channel_tunnel_out.sv */
// sending half of one tunnel end
// holds a credit counter per channel and merges the channels onto the link
// credit flits go first once any pending count reaches the threshold,
// otherwise a round-robin pick among channels with a word and a credit

`timescale 1ns/10ps

module channel_tunnel_out
   import tunnel_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         arst_n_i,

   // channel inputs
   input  ch_word_t    [num_ch_lp-1:0]  ch_data_i,
   input  logic        [num_ch_lp-1:0]  ch_valid_i,
   output logic        [num_ch_lp-1:0]  ch_ready_o,

   // credits coming back from the far end
   input  credit_vec_t                  local_credit_i,
   input  logic                         local_credit_valid_i,

   // counts owed to the far end
   input  credit_vec_t                  pending_credit_i,
   output logic                         pending_clear_o,

   // to the link
   output tunnel_flit_t                 link_o,
   output logic                         link_valid_o,
   input  logic                         link_ready_i
);

   credit_vec_t                 credit_q;
   credit_vec_t                 credit_d;
   logic [num_ch_lp-1:0]        eligible;
   logic [num_ch_lp-1:0]        grant_oh;
   logic [tag_width_lp-1:0]     grant_idx;
   logic [tag_width_lp-1:0]     rr_ptr;
   logic                        grant_found;
   logic                        send_credit;
   logic                        data_fire;
   ch_word_t                    grant_data;

   // a channel competes only with a word waiting and a credit left
   for (genvar i = 0; i < num_ch_lp; i++)
   begin : g_elig
      assign eligible[i] = ch_valid_i[i] & (credit_q[i] != '0);
   end

   // any channel at threshold forces a credit flit
   always_comb
   begin
      send_credit = 1'b0;
      for (int i = 0; i < num_ch_lp; i++)
      begin
         if (pending_credit_i[i] >= credit_width_lp'(credit_thresh_lp))
            send_credit = 1'b1;
      end
   end

   // round-robin search starting at rr_ptr
   always_comb
   begin
      int idx;
      grant_found = 1'b0;
      grant_idx   = '0;
      grant_oh    = '0;
      grant_data  = '0;
      for (int k = 0; k < num_ch_lp; k++)
      begin
         idx = int'(rr_ptr) + k;
         if (idx >= num_ch_lp)
            idx = idx - num_ch_lp;
         if (!grant_found && eligible[idx])
         begin
            grant_found   = 1'b1;
            grant_idx     = tag_width_lp'(idx);
            grant_oh[idx] = 1'b1;
            grant_data    = ch_data_i[idx];
         end
      end
   end

   assign link_valid_o    = send_credit | grant_found;
   assign pending_clear_o = send_credit & link_ready_i;
   assign data_fire       = ~send_credit & grant_found & link_ready_i;
   assign ch_ready_o      = data_fire ? grant_oh : '0;

   // credit flit carries the pending vector zero-extended into the payload
   always_comb
   begin
      if (send_credit)
      begin
         link_o.tag     = tag_width_lp'(credit_tag_lp);
         link_o.payload = {{(data_width_lp-num_ch_lp*credit_width_lp){1'b0}},
                           pending_credit_i};
      end
      else
      begin
         link_o.tag     = grant_idx;
         link_o.payload = grant_data;
      end
   end

   // spend one credit per accepted word, add back whatever returns
   always_comb
   begin
      for (int i = 0; i < num_ch_lp; i++)
      begin
         credit_d[i] = credit_q[i] - credit_width_lp'(ch_ready_o[i] & ch_valid_i[i]);
         if (local_credit_valid_i)
            credit_d[i] = credit_d[i] + local_credit_i[i];
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int i = 0; i < num_ch_lp; i++)
            credit_q[i] <= credit_width_lp'(remote_credits_lp);
         rr_ptr <= '0;
      end
      else
      begin
         credit_q <= credit_d;
         // pointer moves one past the channel just served
         if (data_fire)
         begin
            if (grant_idx == tag_width_lp'(num_ch_lp - 1))
               rr_ptr <= '0;
            else
               rr_ptr <= grant_idx + 1'b1;
         end
      end
   end

endmodule

/* source/link_stage.sv */
// one registered pipeline stage on the link, main register plus skid entry
// ready_o comes straight from a flop, throughput stays at one flit per cycle
// flits leave in order and unchanged one cycle after they are taken

`timescale 1ns/10ps

module link_stage
   import tunnel_pkg::*;
(
   input  logic         clk_i,
   input  logic         arst_n_i,
   input  tunnel_flit_t flit_i,
   input  logic         valid_i,
   output logic         ready_o,
   output tunnel_flit_t flit_o,
   output logic         valid_o,
   input  logic         ready_i
);

   tunnel_flit_t flit_q;
   tunnel_flit_t skid_q;
   logic         valid_q;
   logic         skid_valid_q;
   logic         in_fire;
   logic         main_free;

   assign ready_o   = ~skid_valid_q;
   assign in_fire   = valid_i & ready_o;
   // main register empties or drains this cycle
   assign main_free = ~valid_q | ready_i;

   assign flit_o  = flit_q;
   assign valid_o = valid_q;

   always_ff @(posedge clk_i)
   begin
      // skid entry has priority, it holds the older flit
      if (main_free && (skid_valid_q || in_fire))
         flit_q <= skid_valid_q ? skid_q : flit_i;
      if (!main_free && in_fire)
         skid_q <= flit_i;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         valid_q      <= 1'b0;
         skid_valid_q <= 1'b0;
      end
      else if (main_free)
      begin
         valid_q      <= skid_valid_q | in_fire;
         skid_valid_q <= 1'b0;
      end
      else if (in_fire)
         skid_valid_q <= 1'b1;
   end

endmodule

/* source/tagged_demux_fifo.sv */
// splits the incoming flit stream by tag into one small fifo per channel
// credit flits skip storage and show up on the credit outputs the same cycle
// link ready only drops when the selected fifo is full

`timescale 1ns/10ps

module tagged_demux_fifo
   import tunnel_pkg::*;
(
   input  logic                            clk_i,
   input  logic                            arst_n_i,

   // from the link
   input  tunnel_flit_t                    flit_i,
   input  logic                            flit_valid_i,
   output logic                            flit_ready_o,

   // per-channel outputs (valid/ready)
   output ch_word_t     [num_ch_lp-1:0]    ch_data_o,
   output logic         [num_ch_lp-1:0]    ch_valid_o,
   input  logic         [num_ch_lp-1:0]    ch_ready_i,

   // credit flit contents, no ready, consumer always takes it
   output credit_vec_t                     credit_o,
   output logic                            credit_valid_o
);

   logic                 is_credit;
   logic [num_ch_lp-1:0] tag_hit;
   logic [num_ch_lp-1:0] full;
   logic [num_ch_lp-1:0] wr_en;
   logic [num_ch_lp-1:0] rd_en;

   assign is_credit = (flit_i.tag == tag_width_lp'(credit_tag_lp));

   // credit flits never back-pressure
   assign flit_ready_o = is_credit | (|(tag_hit & ~full));

   // low bits of the payload hold the credit vector
   assign credit_o       = flit_i.payload[num_ch_lp*credit_width_lp-1:0];
   assign credit_valid_o = flit_valid_i & is_credit;

   for (genvar i = 0; i < num_ch_lp; i++)
   begin : g_ch
      logic [fifo_ptr_width_lp-1:0] wr_ptr;
      logic [fifo_ptr_width_lp-1:0] rd_ptr;
      logic [credit_width_lp-1:0]   count;
      ch_word_t                     mem [remote_credits_lp];

      assign tag_hit[i] = ~is_credit & (flit_i.tag == tag_width_lp'(i));
      assign full[i]    = (count == credit_width_lp'(remote_credits_lp));
      assign wr_en[i]   = flit_valid_i & tag_hit[i] & ~full[i];
      assign rd_en[i]   = ch_valid_o[i] & ch_ready_i[i];

      // head of the fifo drives the channel directly
      assign ch_valid_o[i] = (count != '0);
      assign ch_data_o[i]  = mem[rd_ptr];

      always_ff @(posedge clk_i)
      begin
         if (wr_en[i])
            mem[wr_ptr] <= flit_i.payload;
      end

      // pointers wrap naturally, depth is a power of two
      always_ff @(posedge clk_i or negedge arst_n_i)
      begin
         if (!arst_n_i)
         begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
         end
         else
         begin
            if (wr_en[i])
               wr_ptr <= wr_ptr + 1'b1;
            if (rd_en[i])
               rd_ptr <= rd_ptr + 1'b1;
            count <= count + credit_width_lp'(wr_en[i]) - credit_width_lp'(rd_en[i]);
         end
      end
   end

endmodule

/* source/tunnel_pair.sv */
// top level, two tunnel ends looped through one link stage each way
// words entering on a_ carry over to b_ outputs and the other way round

`timescale 1ns/10ps

module tunnel_pair
   import tunnel_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      arst_n_i,

   // end A
   input  ch_word_t [num_ch_lp-1:0]  a_data_i,
   input  logic     [num_ch_lp-1:0]  a_valid_i,
   output logic     [num_ch_lp-1:0]  a_ready_o,
   output ch_word_t [num_ch_lp-1:0]  a_data_o,
   output logic     [num_ch_lp-1:0]  a_valid_o,
   input  logic     [num_ch_lp-1:0]  a_ready_i,

   // end B
   input  ch_word_t [num_ch_lp-1:0]  b_data_i,
   input  logic     [num_ch_lp-1:0]  b_valid_i,
   output logic     [num_ch_lp-1:0]  b_ready_o,
   output ch_word_t [num_ch_lp-1:0]  b_data_o,
   output logic     [num_ch_lp-1:0]  b_valid_o,
   input  logic     [num_ch_lp-1:0]  b_ready_i
);

   // A to B, before and after the stage
   tunnel_flit_t a_tx_flit, ab_flit;
   logic         a_tx_valid, a_tx_ready, ab_valid, ab_ready;

   // B to A, before and after the stage
   tunnel_flit_t b_tx_flit, ba_flit;
   logic         b_tx_valid, b_tx_ready, ba_valid, ba_ready;

   channel_tunnel end_a (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .ch_data_i (a_data_i), .ch_valid_i (a_valid_i), .ch_ready_o (a_ready_o),
      .ch_data_o (a_data_o), .ch_valid_o (a_valid_o), .ch_ready_i (a_ready_i),
      .link_o (a_tx_flit), .link_valid_o (a_tx_valid), .link_ready_i (a_tx_ready),
      .link_i (ba_flit), .link_valid_i (ba_valid), .link_ready_o (ba_ready)
   );

   link_stage a_to_b (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .flit_i (a_tx_flit), .valid_i (a_tx_valid), .ready_o (a_tx_ready),
      .flit_o (ab_flit), .valid_o (ab_valid), .ready_i (ab_ready)
   );

   channel_tunnel end_b (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .ch_data_i (b_data_i), .ch_valid_i (b_valid_i), .ch_ready_o (b_ready_o),
      .ch_data_o (b_data_o), .ch_valid_o (b_valid_o), .ch_ready_i (b_ready_i),
      .link_o (b_tx_flit), .link_valid_o (b_tx_valid), .link_ready_i (b_tx_ready),
      .link_i (ab_flit), .link_valid_i (ab_valid), .link_ready_o (ab_ready)
   );

   link_stage b_to_a (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .flit_i (b_tx_flit), .valid_i (b_tx_valid), .ready_o (b_tx_ready),
      .flit_o (ba_flit), .valid_o (ba_valid), .ready_i (ba_ready)
   );

endmodule

/* source/tunnel_pkg.sv */
// shared sizes and types for the channel tunnel
// every tunnel module pulls these in through a wildcard import
// a flit is a channel tag plus one word, or a credit flit carrying a credit vector

package tunnel_pkg;

   // tunnelled channels and their word width
   localparam int num_ch_lp         = 3;
   localparam int data_width_lp     = 16;

   // tags 0..num_ch_lp-1 select a channel, num_ch_lp marks a credit flit
   localparam int tag_width_lp      = 2;
   localparam int credit_tag_lp     = num_ch_lp;

   // receive fifo depth, also the starting credit count per channel
   localparam int remote_credits_lp = 4;
   localparam int credit_width_lp   = 3;
   localparam int fifo_ptr_width_lp = $clog2(remote_credits_lp);

   // pending consumed words on one channel before a credit flit goes out
   // kept at or below half the fifo depth so returns never stall
   localparam int credit_thresh_lp  = 2;

   typedef logic [data_width_lp-1:0] ch_word_t;

   typedef struct packed {
      logic [tag_width_lp-1:0] tag;
      ch_word_t                payload;
   } tunnel_flit_t;

   // one count per channel, channel 0 in the low bits
   typedef logic [num_ch_lp-1:0][credit_width_lp-1:0] credit_vec_t;

endpackage

/* tests/tb_tunnel_pair.sv */
// testbench for the tunnel pair, traffic in both directions at once
// LFSR driven words and handshakes, one scoreboard queue per direction and channel
// concurrent assertions check order, data, reset state and the credit limit

`timescale 1ns/10ps

module tb_tunnel_pair
   import tunnel_pkg::*;
();

   localparam int words_per_phase_lp = 24;
   localparam int hold_words_lp      = 12;
   // more than three fifo depths after the stall
   localparam int words_after_lp     = 16;
   localparam int settle_cycles_lp   = 16;
   localparam int total_words_lp     =
      2 * num_ch_lp * (words_per_phase_lp + hold_words_lp + words_after_lp);
   localparam int timeout_lp         = 40 * total_words_lp;

   logic                            clk_i = 1'b0;
   logic                            arst_n_i;
   ch_word_t    [num_ch_lp-1:0]     a_data_i, a_data_o, b_data_i, b_data_o;
   logic        [num_ch_lp-1:0]     a_valid_i, a_ready_o, a_valid_o, a_ready_i;
   logic        [num_ch_lp-1:0]     b_valid_i, b_ready_o, b_valid_o, b_ready_i;

   // ab is A in to B out, ba the reverse
   ch_word_t                        ab_q [num_ch_lp][$];
   ch_word_t                        ba_q [num_ch_lp][$];
   ch_word_t                        ab_head [num_ch_lp];
   ch_word_t                        ba_head [num_ch_lp];
   logic        [num_ch_lp-1:0]     ab_some, ba_some;

   int                              a_sent [num_ch_lp];
   int                              b_sent [num_ch_lp];
   int                              a_target [num_ch_lp];
   int                              b_target [num_ch_lp];
   logic        [num_ch_lp-1:0]     a_fired, b_fired, a_force, b_force;
   logic                            hold;
   int                              held_cnt;
   logic                            rst_d;
   logic                            post_rst;
   logic        [31:0]              lfsr_q;
   int                              cycles = 0;

   tunnel_pair DUT (.*);

   always #20 clk_i = ~clk_i;

   assign post_rst = arst_n_i & ~rst_d;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         val    = {val[30:0], lfsr_q[0]};
      end
   endtask

   // a valid word stays put until it transfers, then a new pick
   task automatic drive_inputs();
      logic [31:0] r;
      for (int i = 0; i < num_ch_lp; i++)
      begin
         if (!(a_valid_i[i] && !a_fired[i]))
         begin
            rand_bits(1, r);
            a_valid_i[i] = (a_sent[i] < a_target[i]) && (a_force[i] || r[0]);
            rand_bits(data_width_lp, r);
            a_data_i[i] = r[data_width_lp-1:0];
         end
         if (!(b_valid_i[i] && !b_fired[i]))
         begin
            rand_bits(1, r);
            b_valid_i[i] = (b_sent[i] < b_target[i]) && (b_force[i] || r[0]);
            rand_bits(data_width_lp, r);
            b_data_i[i] = r[data_width_lp-1:0];
         end
         rand_bits(1, r);
         a_ready_i[i] = r[0];
         rand_bits(1, r);
         // channel 1 at B stalls while held
         b_ready_i[i] = r[0] && !(hold && i == 1);
      end
   endtask

   function automatic logic traffic_done(input logic skip_a1);
      logic done;
      done = 1'b1;
      for (int i = 0; i < num_ch_lp; i++)
      begin
         if (!(skip_a1 && i == 1) && (a_sent[i] != a_target[i] || ab_q[i].size() != 0))
            done = 1'b0;
         if (b_sent[i] != b_target[i] || ba_q[i].size() != 0)
            done = 1'b0;
      end
      return done;
   endfunction

   task automatic run_until_done(input logic skip_a1);
      logic done;
      done = 1'b0;
      while (!done)
      begin
         @(negedge clk_i);
         drive_inputs();
         done = traffic_done(skip_a1) && (!skip_a1 || held_cnt == remote_credits_lp);
      end
   endtask

   // scoreboard, pops before pushes so a stray output never eats a fresh word
   always @(posedge clk_i)
   begin
      rst_d <= arst_n_i;
      if (!arst_n_i)
      begin
         for (int i = 0; i < num_ch_lp; i++)
         begin
            a_sent[i] <= 0;
            b_sent[i] <= 0;
         end
         ab_some  <= '0;
         ba_some  <= '0;
         a_fired  <= '0;
         b_fired  <= '0;
         held_cnt <= 0;
      end
      else
      begin
         for (int i = 0; i < num_ch_lp; i++)
         begin
            if (b_valid_o[i] && b_ready_i[i] && ab_q[i].size() != 0)
               void'(ab_q[i].pop_front());
            if (a_valid_o[i] && a_ready_i[i] && ba_q[i].size() != 0)
               void'(ba_q[i].pop_front());
            if (a_valid_i[i] && a_ready_o[i])
            begin
               ab_q[i].push_back(a_data_i[i]);
               a_sent[i] <= a_sent[i] + 1;
            end
            if (b_valid_i[i] && b_ready_o[i])
            begin
               ba_q[i].push_back(b_data_i[i]);
               b_sent[i] <= b_sent[i] + 1;
            end
            // head as seen by the next edge
            ab_some[i] <= (ab_q[i].size() != 0);
            ab_head[i] <= (ab_q[i].size() != 0) ? ab_q[i][0] : '0;
            ba_some[i] <= (ba_q[i].size() != 0);
            ba_head[i] <= (ba_q[i].size() != 0) ? ba_q[i][0] : '0;
         end
         a_fired <= a_valid_i & a_ready_o;
         b_fired <= b_valid_i & b_ready_o;
         if (hold && a_valid_i[1] && a_ready_o[1])
            held_cnt <= held_cnt + 1;
      end
   end

   always @(posedge clk_i)
   begin
      cycles <= cycles + 1;
      if (cycles >= timeout_lp)
         abort_run($sformatf("timeout after %0d cycles with traffic not drained", cycles));
   end

   // outputs quiet through reset and the first cycle after it
   rst_quiet : assert property (@(posedge clk_i)
      !arst_n_i || post_rst |-> a_valid_o == '0 && b_valid_o == '0)
   else
      abort_run($sformatf("ERR a_valid_o 0x%h b_valid_o 0x%h expected 0x0 at reset",
                          $sampled(a_valid_o), $sampled(b_valid_o)));

   // all channels offer a word right out of reset, a full credit pool must take one
   rst_ready : assert property (@(posedge clk_i)
      post_rst |-> (a_ready_o & a_valid_i) != '0 && (b_ready_o & b_valid_i) != '0)
   else
      abort_run($sformatf("ERR a_ready_o 0x%h b_ready_o 0x%h with all inputs valid",
                          $sampled(a_ready_o), $sampled(b_ready_o)));

   // the stalled channel never takes more words than the far fifo holds
   hold_limit : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      hold && a_valid_i[1] && a_ready_o[1] |-> held_cnt < remote_credits_lp)
   else
      abort_run($sformatf("ERR held_cnt 0x%h already at credit limit 0x%h",
                          $sampled(held_cnt), remote_credits_lp));

   for (genvar i = 0; i < num_ch_lp; i++)
   begin : g_chk
      ab_known : assert property (@(posedge clk_i) disable iff (!arst_n_i)
         b_valid_o[i] && b_ready_i[i] |-> ab_some[i])
      else
         abort_run($sformatf("word left B channel %0d with nothing sent on it", i));

      ab_order : assert property (@(posedge clk_i) disable iff (!arst_n_i)
         b_valid_o[i] && b_ready_i[i] |-> b_data_o[i] == ab_head[i])
      else
         abort_run($sformatf("ERR b_data_o[%0d] 0x%h expected 0x%h", i,
                             $sampled(b_data_o[i]), $sampled(ab_head[i])));

      ba_known : assert property (@(posedge clk_i) disable iff (!arst_n_i)
         a_valid_o[i] && a_ready_i[i] |-> ba_some[i])
      else
         abort_run($sformatf("word left A channel %0d with nothing sent on it", i));

      ba_order : assert property (@(posedge clk_i) disable iff (!arst_n_i)
         a_valid_o[i] && a_ready_i[i] |-> a_data_o[i] == ba_head[i])
      else
         abort_run($sformatf("ERR a_data_o[%0d] 0x%h expected 0x%h", i,
                             $sampled(a_data_o[i]), $sampled(ba_head[i])));
   end

   initial
   begin
      arst_n_i  = 1'b0;
      a_data_i  = '0;
      a_valid_i = '0;
      a_ready_i = '0;
      b_data_i  = '0;
      b_valid_i = '0;
      b_ready_i = '0;
      a_force   = '0;
      b_force   = '0;
      hold      = 1'b0;
      lfsr_q    = 32'h2ad0_9c67;
      for (int i = 0; i < num_ch_lp; i++)
      begin
         a_target[i] = 0;
         b_target[i] = 0;
      end
      repeat (16) @(negedge clk_i);
      arst_n_i = 1'b1;

      // random traffic everywhere, every channel valid in the first cycle
      for (int i = 0; i < num_ch_lp; i++)
      begin
         a_target[i] = words_per_phase_lp;
         b_target[i] = words_per_phase_lp;
      end
      a_force = '1;
      b_force = '1;
      drive_inputs();
      a_force = '0;
      b_force = '0;
      run_until_done(1'b0);

      // stall B channel 1 with A channel 1 pushing, the rest keep flowing
      hold         = 1'b1;
      b_ready_i[1] = 1'b0;
      for (int i = 0; i < num_ch_lp; i++)
      begin
         if (i != 1)
            a_target[i] = a_target[i] + hold_words_lp;
         b_target[i] = b_target[i] + hold_words_lp;
      end
      a_target[1] = a_sent[1] + remote_credits_lp + 1;
      a_force[1]  = 1'b1;
      run_until_done(1'b1);
      // window for a stray extra accept on channel 1
      repeat (settle_cycles_lp)
      begin
         @(negedge clk_i);
         drive_inputs();
      end

      // release, held words drain and credits must come back
      hold       = 1'b0;
      a_force[1] = 1'b0;
      for (int i = 0; i < num_ch_lp; i++)
      begin
         a_target[i] = a_sent[i] + words_after_lp;
         b_target[i] = b_sent[i] + words_after_lp;
      end
      run_until_done(1'b0);

      $display("Result: PASSED");
      $finish;
   end

endmodule
